//--- common/id_consts.svh
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

`define INSTR_W          32
`define REG_ADDR_W       5
`define EXCP_W           9
`define FETCH_EXCP_W     4
`define PLV_USER         2'd3

// ALU op codes where zero means no sub-decoder matched
`define ALUOP_W          8
`define EXE_NOP_OP       8'h00
`define EXE_ADD_OP       8'h01
`define EXE_SUB_OP       8'h02
`define EXE_AND_OP       8'h03
`define EXE_OR_OP        8'h04
`define EXE_XOR_OP       8'h05
`define EXE_BREAK_OP     8'h06
`define EXE_SYSCALL_OP   8'h07
`define EXE_ADDI_OP      8'h08
`define EXE_ORI_OP       8'h09
`define EXE_LDW_OP       8'h0a
`define EXE_STW_OP       8'h0b
`define EXE_BEQ_OP       8'h0c
`define EXE_BNE_OP       8'h0d
`define EXE_JIRL_OP      8'h0e
`define EXE_LU12I_OP     8'h0f
`define EXE_PCADDU12I_OP 8'h10
`define EXE_B_OP         8'h11
`define EXE_BL_OP        8'h12
`define EXE_CSRRD_OP     8'h13
`define EXE_CSRWR_OP     8'h14
`define EXE_CSRXCHG_OP   8'h15
`define EXE_ERTN_OP      8'h16
`define EXE_IDLE_OP      8'h17

// Result class for the execute stage
`define ALUSEL_W         3
`define ALUSEL_ARITH     3'd1
`define ALUSEL_LOGIC     3'd2
`define ALUSEL_MEM       3'd3
`define ALUSEL_BRANCH    3'd4
`define ALUSEL_CSR       3'd5

`endif

//--- common/isa_pkg.sv
`include "id_consts.svh"

package isa_pkg;

    typedef struct packed {
        logic [16:0]            opcode;
        logic [`REG_ADDR_W-1:0] rk;
        logic [`REG_ADDR_W-1:0] rj;
        logic [`REG_ADDR_W-1:0] rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]             opcode;
        logic [11:0]            imm12;
        logic [`REG_ADDR_W-1:0] rj;
        logic [`REG_ADDR_W-1:0] rd;
    } fmt_2ri12_t;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [15:0]            offs16;
        logic [`REG_ADDR_W-1:0] rj;
        logic [`REG_ADDR_W-1:0] rd;
    } fmt_2ri16_t;

    typedef struct packed {
        logic [6:0]             opcode;
        logic [19:0]            imm20;
        logic [`REG_ADDR_W-1:0] rd;
    } fmt_1ri20_t;

    // High part of the offset sits in the low bits
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } fmt_i26_t;

    typedef struct packed {
        logic [7:0]             opcode;
        logic [13:0]            csr_num;
        logic [`REG_ADDR_W-1:0] rj;
        logic [`REG_ADDR_W-1:0] rd;
    } fmt_csr_t;

    typedef union packed {
        fmt_3r_t    r3;
        fmt_2ri12_t ri12;
        fmt_2ri16_t ri16;
        fmt_1ri20_t ri20;
        fmt_i26_t   i26;
        fmt_csr_t   csr;
    } instr_word_u;

    // Bit positions in excp_num
    // Fetch code spans four bits from EXCP_FETCH up
    typedef enum logic [3:0] {
        EXCP_INT   = 4'd0,
        EXCP_FETCH = 4'd1,
        EXCP_SYS   = 4'd5,
        EXCP_BRK   = 4'd6,
        EXCP_INE   = 4'd7,
        EXCP_IPE   = 4'd8
    } excp_bit_e;

endpackage

//--- common/pipe_pkg.sv
`include "id_consts.svh"

package pipe_pkg;

    import isa_pkg::*;

    typedef struct packed {
        logic                     valid;
        logic [`INSTR_W-1:0]      pc;
        instr_word_u              instr;
        logic                     is_last_in_block;
        logic                     excp;
        logic [`FETCH_EXCP_W-1:0] excp_num;
    } instr_buffer_info_t;

    // All zero when the sub-decoder does not match
    typedef struct packed {
        logic                            hit;
        logic [`ALUOP_W-1:0]             aluop;
        logic [`ALUSEL_W-1:0]            alusel;
        logic [1:0]                      reg_read_valid;
        logic [1:0][`REG_ADDR_W-1:0]     reg_read_addr;
        logic                            reg_write_valid;
        logic [`REG_ADDR_W-1:0]          reg_write_addr;
        logic                            use_imm;
        logic [`INSTR_W-1:0]             imm;
        logic                            is_kernel;
        logic                            is_refetch;
        logic                            is_break;
        logic                            is_syscall;
    } sub_decode_t;

    typedef struct packed {
        instr_buffer_info_t              instr_info;
        logic [`ALUOP_W-1:0]             aluop;
        logic [`ALUSEL_W-1:0]            alusel;
        logic [1:0]                      reg_read_valid;
        logic [1:0][`REG_ADDR_W-1:0]     reg_read_addr;
        logic                            reg_write_valid;
        logic [`REG_ADDR_W-1:0]          reg_write_addr;
        logic                            use_imm;
        logic [`INSTR_W-1:0]             imm;
        logic                            refetch;
        logic                            excp;
        logic [`EXCP_W-1:0]              excp_num;
    } id_dispatch_t;

endpackage

//--- decode/decoder_3r.sv
`timescale 1ns/1ps
`include "id_consts.svh"

module decoder_3r import pipe_pkg::*; (
    input  instr_buffer_info_t instr_info_i,
    output sub_decode_t        result_o
);

    logic [`ALUOP_W-1:0]  op;
    logic [`ALUSEL_W-1:0] sel;
    logic                 alu_op;

    always_comb begin
        op  = `EXE_NOP_OP;
        sel = '0;
        case (instr_info_i.instr.r3.opcode)
            17'h00020: begin
                op  = `EXE_ADD_OP;
                sel = `ALUSEL_ARITH;
            end
            17'h00022: begin
                op  = `EXE_SUB_OP;
                sel = `ALUSEL_ARITH;
            end
            17'h00029: begin
                op  = `EXE_AND_OP;
                sel = `ALUSEL_LOGIC;
            end
            17'h0002a: begin
                op  = `EXE_OR_OP;
                sel = `ALUSEL_LOGIC;
            end
            17'h0002b: begin
                op  = `EXE_XOR_OP;
                sel = `ALUSEL_LOGIC;
            end
            17'h00054: op = `EXE_BREAK_OP;
            17'h00056: op = `EXE_SYSCALL_OP;
            default: ;
        endcase
    end

    // Traps carry no result class and touch no registers
    assign alu_op = (sel != '0);

    always_comb begin
        result_o = '0;
        if (instr_info_i.valid && op != `EXE_NOP_OP) begin
            result_o.hit        = 1'b1;
            result_o.aluop      = op;
            result_o.alusel     = sel;
            result_o.is_break   = (op == `EXE_BREAK_OP);
            result_o.is_syscall = (op == `EXE_SYSCALL_OP);
            if (alu_op) begin
                result_o.reg_read_valid  = 2'b11;
                result_o.reg_read_addr   = {instr_info_i.instr.r3.rk, instr_info_i.instr.r3.rj};
                result_o.reg_write_valid = 1'b1;
                result_o.reg_write_addr  = instr_info_i.instr.r3.rd;
            end
        end
    end

endmodule

//--- decode/decoder_imm.sv
`timescale 1ns/1ps
`include "id_consts.svh"

module decoder_imm import isa_pkg::*, pipe_pkg::*; (
    input  instr_buffer_info_t instr_info_i,
    output sub_decode_t        result_o
);

    fmt_2ri12_t          ri12;
    fmt_2ri16_t          ri16;
    fmt_1ri20_t          ri20;
    fmt_i26_t            i26;
    logic [`ALUOP_W-1:0] op;
    logic [`INSTR_W-1:0] simm12, zimm12, offs16, imm20, offs26;
    logic                rd_rj, rd_rd, wr_rd;

    assign ri12 = instr_info_i.instr.ri12;
    assign ri16 = instr_info_i.instr.ri16;
    assign ri20 = instr_info_i.instr.ri20;
    assign i26  = instr_info_i.instr.i26;

    assign simm12 = {{20{ri12.imm12[11]}}, ri12.imm12};
    assign zimm12 = {20'b0, ri12.imm12};
    assign offs16 = {{14{ri16.offs16[15]}}, ri16.offs16, 2'b00};
    assign imm20  = {ri20.imm20, 12'b0};
    assign offs26 = {{4{i26.offs_hi[9]}}, i26.offs_hi, i26.offs_lo, 2'b00};

    // Opcode prefixes of the four formats do not overlap
    always_comb begin
        op = `EXE_NOP_OP;
        case (ri12.opcode)
            10'h00a: op = `EXE_ADDI_OP;
            10'h00e: op = `EXE_ORI_OP;
            10'h0a2: op = `EXE_LDW_OP;
            10'h0a6: op = `EXE_STW_OP;
            default: ;
        endcase
        case (ri16.opcode)
            6'h13: op = `EXE_JIRL_OP;
            6'h16: op = `EXE_BEQ_OP;
            6'h17: op = `EXE_BNE_OP;
            default: ;
        endcase
        case (ri20.opcode)
            7'h0a: op = `EXE_LU12I_OP;
            7'h0e: op = `EXE_PCADDU12I_OP;
            default: ;
        endcase
        case (i26.opcode)
            6'h14: op = `EXE_B_OP;
            6'h15: op = `EXE_BL_OP;
            default: ;
        endcase
    end

    assign rd_rj = op inside {`EXE_ADDI_OP, `EXE_ORI_OP, `EXE_LDW_OP, `EXE_STW_OP,
                              `EXE_BEQ_OP, `EXE_BNE_OP, `EXE_JIRL_OP};
    assign rd_rd = op inside {`EXE_STW_OP, `EXE_BEQ_OP, `EXE_BNE_OP};
    assign wr_rd = op inside {`EXE_ADDI_OP, `EXE_ORI_OP, `EXE_LDW_OP, `EXE_JIRL_OP,
                              `EXE_LU12I_OP, `EXE_PCADDU12I_OP};

    // rj and rd sit in the same bits for every format here
    always_comb begin
        result_o = '0;
        if (instr_info_i.valid && op != `EXE_NOP_OP) begin
            result_o.hit              = 1'b1;
            result_o.aluop            = op;
            result_o.use_imm          = 1'b1;
            result_o.reg_read_valid   = {rd_rd, rd_rj};
            result_o.reg_read_addr[0] = rd_rj ? ri12.rj : '0;
            result_o.reg_read_addr[1] = rd_rd ? ri12.rd : '0;
            result_o.reg_write_valid  = wr_rd | (op == `EXE_BL_OP);
            if (wr_rd) begin
                result_o.reg_write_addr = ri12.rd;
            end else if (op == `EXE_BL_OP) begin
                // Link register
                result_o.reg_write_addr = 5'd1;
            end
            case (op)
                `EXE_ADDI_OP: begin
                    result_o.alusel = `ALUSEL_ARITH;
                    result_o.imm    = simm12;
                end
                `EXE_LDW_OP, `EXE_STW_OP: begin
                    result_o.alusel = `ALUSEL_MEM;
                    result_o.imm    = simm12;
                end
                `EXE_ORI_OP: begin
                    result_o.alusel = `ALUSEL_LOGIC;
                    result_o.imm    = zimm12;
                end
                `EXE_LU12I_OP, `EXE_PCADDU12I_OP: begin
                    result_o.alusel = `ALUSEL_ARITH;
                    result_o.imm    = imm20;
                end
                `EXE_B_OP, `EXE_BL_OP: begin
                    result_o.alusel = `ALUSEL_BRANCH;
                    result_o.imm    = offs26;
                end
                default: begin
                    result_o.alusel = `ALUSEL_BRANCH;
                    result_o.imm    = offs16;
                end
            endcase
        end
    end

endmodule

//--- decode/decoder_csr.sv
`timescale 1ns/1ps
`include "id_consts.svh"

module decoder_csr import isa_pkg::*, pipe_pkg::*; (
    input  instr_buffer_info_t instr_info_i,
    output sub_decode_t        result_o
);

    fmt_csr_t            csr;
    logic [`ALUOP_W-1:0] op;

    assign csr = instr_info_i.instr.csr;

    always_comb begin
        op = `EXE_NOP_OP;
        if (csr.opcode == 8'h04) begin
            // rj selects the access kind
            case (csr.rj)
                5'd0: op = `EXE_CSRRD_OP;
                5'd1: op = `EXE_CSRWR_OP;
                default: op = `EXE_CSRXCHG_OP;
            endcase
        end else if (instr_info_i.instr == 32'h0648_3800) begin
            op = `EXE_ERTN_OP;
        end else if (instr_info_i.instr.r3.opcode == 17'h00c91) begin
            op = `EXE_IDLE_OP;
        end
    end

    always_comb begin
        result_o = '0;
        if (instr_info_i.valid && op != `EXE_NOP_OP) begin
            result_o.hit        = 1'b1;
            result_o.aluop      = op;
            result_o.alusel     = `ALUSEL_CSR;
            result_o.is_kernel  = 1'b1;
            result_o.is_refetch = (op == `EXE_ERTN_OP);
            if (op inside {`EXE_CSRRD_OP, `EXE_CSRWR_OP, `EXE_CSRXCHG_OP}) begin
                result_o.use_imm          = 1'b1;
                result_o.imm              = {18'b0, csr.csr_num};
                result_o.reg_write_valid  = 1'b1;
                result_o.reg_write_addr   = csr.rd;
                // Slot 1 holds the write data, slot 0 the xchg mask
                result_o.reg_read_valid   = {op != `EXE_CSRRD_OP, op == `EXE_CSRXCHG_OP};
                result_o.reg_read_addr[1] = (op != `EXE_CSRRD_OP) ? csr.rd : '0;
                result_o.reg_read_addr[0] = (op == `EXE_CSRXCHG_OP) ? csr.rj : '0;
            end
        end
    end

endmodule

//--- decode/id.sv
`timescale 1ns/1ps
`include "id_consts.svh"

module id import isa_pkg::*, pipe_pkg::*; (
    input  instr_buffer_info_t instr_buffer_i,
    input  logic               has_int_i,
    input  logic [1:0]         csr_plv_i,
    output id_dispatch_t       dispatch_o
);

    sub_decode_t                res_3r, res_imm, res_csr, merged;
    logic                       valid;
    logic                       fetch_excp, int_pending;
    logic [`FETCH_EXCP_W-1:0]   fetch_code;
    logic                       excp_ine, excp_ipe, excp;
    logic [`EXCP_W-1:0]         excp_num;

    decoder_3r u_decoder_3r (
        .instr_info_i (instr_buffer_i),
        .result_o     (res_3r)
    );

    decoder_imm u_decoder_imm (
        .instr_info_i (instr_buffer_i),
        .result_o     (res_imm)
    );

    decoder_csr u_decoder_csr (
        .instr_info_i (instr_buffer_i),
        .result_o     (res_csr)
    );

    // Non-matching decoders output zero, so OR picks the one hit
    assign merged = sub_decode_t'(res_3r | res_imm | res_csr);

    assign valid       = instr_buffer_i.valid;
    assign fetch_excp  = valid & instr_buffer_i.excp;
    assign fetch_code  = valid ? instr_buffer_i.excp_num : '0;
    assign int_pending = valid & has_int_i;

    assign excp_ine = valid & ~merged.hit;
    assign excp_ipe = merged.is_kernel & (csr_plv_i == `PLV_USER);
    assign excp     = excp_ipe | excp_ine | merged.is_break | merged.is_syscall |
                      fetch_excp | int_pending;

    always_comb begin
        excp_num = '0;
        excp_num[EXCP_IPE] = excp_ipe;
        excp_num[EXCP_INE] = excp_ine;
        excp_num[EXCP_BRK] = merged.is_break;
        excp_num[EXCP_SYS] = merged.is_syscall;
        excp_num[EXCP_FETCH +: `FETCH_EXCP_W] = fetch_code;
        excp_num[EXCP_INT] = int_pending;
    end

    assign dispatch_o.instr_info.valid            = valid & (merged.hit | excp);
    assign dispatch_o.instr_info.pc               = valid ? instr_buffer_i.pc : '0;
    assign dispatch_o.instr_info.instr            = valid ? instr_buffer_i.instr : '0;
    assign dispatch_o.instr_info.is_last_in_block = valid & instr_buffer_i.is_last_in_block;
    assign dispatch_o.instr_info.excp             = fetch_excp;
    assign dispatch_o.instr_info.excp_num         = fetch_code;

    assign dispatch_o.aluop           = merged.aluop;
    assign dispatch_o.alusel          = merged.alusel;
    assign dispatch_o.reg_read_valid  = merged.reg_read_valid;
    assign dispatch_o.reg_read_addr   = merged.reg_read_addr;
    assign dispatch_o.reg_write_valid = merged.reg_write_valid;
    assign dispatch_o.reg_write_addr  = merged.reg_write_addr;
    assign dispatch_o.use_imm         = merged.use_imm;
    assign dispatch_o.imm             = merged.imm;
    assign dispatch_o.refetch         = merged.is_refetch;
    assign dispatch_o.excp            = excp;
    assign dispatch_o.excp_num        = excp_num;

endmodule

//--- hdl/id_dispatch_reg.sv
`timescale 1ns/1ps

module id_dispatch_reg import pipe_pkg::*; (
    input  logic         clk,
    input  logic         rst_i,
    input  logic         flush_i,
    input  id_dispatch_t dispatch_i,
    output id_dispatch_t dispatch_o
);

    // Flush drops the whole record, not only valid
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            dispatch_o <= '0;
        end else begin
            dispatch_o <= dispatch_i;
        end
    end

endmodule

//--- hdl/id_stage_top.sv
`timescale 1ns/1ps

module id_stage_top import pipe_pkg::*; (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               flush_i,
    input  instr_buffer_info_t instr_buffer_i,
    input  logic               has_int_i,
    input  logic [1:0]         csr_plv_i,
    output id_dispatch_t       dispatch_o
);

    id_dispatch_t id_dispatch;

    id u_id (
        .instr_buffer_i (instr_buffer_i),
        .has_int_i      (has_int_i),
        .csr_plv_i      (csr_plv_i),
        .dispatch_o     (id_dispatch)
    );

    id_dispatch_reg u_id_dispatch_reg (
        .clk        (clk),
        .rst_i      (rst_i),
        .flush_i    (flush_i),
        .dispatch_i (id_dispatch),
        .dispatch_o (dispatch_o)
    );

endmodule

//--- tb/tb_id_stage.sv
`timescale 1ns/1ps
`include "id_consts.svh"

module tb_id_stage import isa_pkg::*, pipe_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 3;
    localparam int TRACE_COLS = 22;

    typedef struct packed {
        instr_buffer_info_t ib;
        logic               has_int;
        logic [1:0]         plv;
        logic               flush;
    } stim_t;

    logic               clk = 1'b0;
    logic               rst_i;
    logic               flush_i;
    instr_buffer_info_t instr_buffer_i;
    logic               has_int_i;
    logic [1:0]         csr_plv_i;
    id_dispatch_t       dispatch_o;

    stim_t              stim_q[$];
    id_dispatch_t       exp_q[$];
    logic               trace_loaded = 1'b0;
    string              cur_ctx = "reset";

    id_stage_top id_stage_top_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .flush_i        (flush_i),
        .instr_buffer_i (instr_buffer_i),
        .has_int_i      (has_int_i),
        .csr_plv_i      (csr_plv_i),
        .dispatch_o     (dispatch_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("error: %s got %h expected %h at %s", name, got, want, cur_ctx);
            stop_with_failure("dispatch record mismatch");
        end
    endtask

    task automatic check_record(input id_dispatch_t want);
        id_dispatch_t       got;
        instr_buffer_info_t gi;
        instr_buffer_info_t wi;
        got = dispatch_o;
        gi  = got.instr_info;
        wi  = want.instr_info;
        compare_value("dispatch_o.instr_info.valid", 32'(gi.valid), 32'(wi.valid));
        compare_value("dispatch_o.instr_info.pc", 32'(gi.pc), 32'(wi.pc));
        compare_value("dispatch_o.instr_info.instr", 32'(gi.instr), 32'(wi.instr));
        compare_value("dispatch_o.instr_info.is_last_in_block", 32'(gi.is_last_in_block),
                      32'(wi.is_last_in_block));
        compare_value("dispatch_o.instr_info.excp", 32'(gi.excp), 32'(wi.excp));
        compare_value("dispatch_o.instr_info.excp_num", 32'(gi.excp_num), 32'(wi.excp_num));
        compare_value("dispatch_o.aluop", 32'(got.aluop), 32'(want.aluop));
        compare_value("dispatch_o.alusel", 32'(got.alusel), 32'(want.alusel));
        compare_value("dispatch_o.reg_read_valid", 32'(got.reg_read_valid),
                      32'(want.reg_read_valid));
        compare_value("dispatch_o.reg_read_addr[0]", 32'(got.reg_read_addr[0]),
                      32'(want.reg_read_addr[0]));
        compare_value("dispatch_o.reg_read_addr[1]", 32'(got.reg_read_addr[1]),
                      32'(want.reg_read_addr[1]));
        compare_value("dispatch_o.reg_write_valid", 32'(got.reg_write_valid),
                      32'(want.reg_write_valid));
        compare_value("dispatch_o.reg_write_addr", 32'(got.reg_write_addr),
                      32'(want.reg_write_addr));
        compare_value("dispatch_o.use_imm", 32'(got.use_imm), 32'(want.use_imm));
        compare_value("dispatch_o.imm", 32'(got.imm), 32'(want.imm));
        compare_value("dispatch_o.refetch", 32'(got.refetch), 32'(want.refetch));
        compare_value("dispatch_o.excp", 32'(got.excp), 32'(want.excp));
        compare_value("dispatch_o.excp_num", 32'(got.excp_num), 32'(want.excp_num));
    endtask

    task automatic load_trace();
        int                  fd;
        int                  n;
        int                  cnt;
        string               line;
        logic [`INSTR_W-1:0] f [TRACE_COLS];
        stim_t               s;
        id_dispatch_t        e;
        fd = $fopen("tb/id_trace.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open tb/id_trace.txt");
        end
        n = $fgets(line, fd);
        while (n != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                cnt = $sscanf(line,
                              "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                              f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                              f[20], f[21]);
                if (cnt != TRACE_COLS) begin
                    stop_with_failure({"malformed trace line: ", line});
                end
                s = '0;
                s.ib.valid            = f[0][0];
                // All ones in the pc column asks for a random pc
                s.ib.pc               = (f[1] == 32'hffff_ffff) ? $urandom() : f[1];
                s.ib.instr            = instr_word_u'(f[2]);
                s.ib.is_last_in_block = f[3][0];
                s.ib.excp             = f[4][0];
                s.ib.excp_num         = f[5][`FETCH_EXCP_W-1:0];
                s.has_int             = f[6][0];
                s.plv                 = f[7][1:0];
                s.flush               = f[8][0];
                e = '0;
                // Buffer fields pass through only for a valid, unflushed entry
                if (s.ib.valid && !s.flush) begin
                    e.instr_info.pc               = s.ib.pc;
                    e.instr_info.instr            = s.ib.instr;
                    e.instr_info.is_last_in_block = s.ib.is_last_in_block;
                    e.instr_info.excp             = s.ib.excp;
                    e.instr_info.excp_num         = s.ib.excp_num;
                end
                e.instr_info.valid = f[9][0];
                e.aluop            = f[10][`ALUOP_W-1:0];
                e.alusel           = f[11][`ALUSEL_W-1:0];
                e.reg_read_valid   = f[12][1:0];
                e.reg_read_addr[0] = f[13][`REG_ADDR_W-1:0];
                e.reg_read_addr[1] = f[14][`REG_ADDR_W-1:0];
                e.reg_write_valid  = f[15][0];
                e.reg_write_addr   = f[16][`REG_ADDR_W-1:0];
                e.use_imm          = f[17][0];
                e.imm              = f[18];
                e.refetch          = f[19][0];
                e.excp             = f[20][0];
                e.excp_num         = f[21][`EXCP_W-1:0];
                stim_q.push_back(s);
                exp_q.push_back(e);
            end
            n = $fgets(line, fd);
        end
        $fclose(fd);
        if (stim_q.size() == 0) begin
            stop_with_failure("trace file holds no entries");
        end
    endtask

    task automatic drive_line(input stim_t s);
        instr_buffer_i <= s.ib;
        has_int_i      <= s.has_int;
        csr_plv_i      <= s.plv;
        flush_i        <= s.flush;
    endtask

    // Watchdog
    initial begin
        wait (trace_loaded);
        #((stim_q.size() + RST_CYCLES + 10) * CLK_PERIOD);
        stop_with_failure("timeout, the trace did not finish in time");
    end

    initial begin
        rst_i          <= 1'b1;
        flush_i        <= 1'b0;
        instr_buffer_i <= '0;
        has_int_i      <= 1'b0;
        csr_plv_i      <= 2'd0;
        void'($urandom(32'h40ce274e));
        load_trace();
        trace_loaded = 1'b1;

        // Live instruction on the input while in reset
        for (int r = 0; r < RST_CYCLES; r++) begin
            @(posedge clk);
            if (r == 0) begin
                drive_line(stim_q[0]);
            end
            if (r == RST_CYCLES - 1) begin
                rst_i <= 1'b0;
            end
            @(negedge clk);
            check_record('0);
        end

        // Entry i is driven at edge i and checked after edge i+1
        for (int i = 0; i <= stim_q.size(); i++) begin
            @(posedge clk);
            if (i < stim_q.size()) begin
                drive_line(stim_q[i]);
            end else begin
                drive_line('0);
            end
            @(negedge clk);
            if (i > 0) begin
                cur_ctx = $sformatf("trace entry %0d", i - 1);
                check_record(exp_q[i - 1]);
            end
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- tb/id_trace.txt
# stim: valid pc(ffffffff=random) instr last fetch_excp fetch_code has_int plv flush
# exp:  valid aluop alusel rd_valid rd_addr0 rd_addr1 wr_valid wr_addr use_imm imm refetch excp excp_num
1 00001000 00100823 0 0 0 0 0 0 1 01 1 3 01 02 1 03 0 00000000 0 0 000
1 00001004 001118a4 0 0 0 0 0 0 1 02 1 3 05 06 1 04 0 00000000 0 0 000
1 ffffffff 0014a507 0 0 0 0 0 0 1 03 2 3 08 09 1 07 0 00000000 0 0 000
1 0000100c 0015316a 1 0 0 0 0 0 1 04 2 3 0b 0c 1 0a 0 00000000 0 0 000
1 00001010 0015f7df 0 0 0 0 0 0 1 05 2 3 1e 1d 1 1f 0 00000000 0 0 000
1 00001014 002a0000 0 0 0 0 0 0 1 06 0 0 00 00 0 00 0 00000000 0 1 040
1 ffffffff 002b0000 0 0 0 0 0 0 1 07 0 0 00 00 0 00 0 00000000 0 1 020
1 00002000 02bffc41 0 0 0 0 0 0 1 08 1 1 02 00 1 01 1 ffffffff 0 0 000
1 00002004 03a000c5 0 0 0 0 0 0 1 09 2 1 06 00 1 05 1 00000800 0 0 000
1 00002008 2880206c 0 0 0 0 0 0 1 0a 3 1 03 00 1 0c 1 00000008 0 0 000
1 0000200c 29bff0a4 0 0 0 0 0 0 1 0b 3 3 05 04 0 00 1 fffffffc 0 0 000
1 00002010 58004022 0 0 0 0 0 0 1 0c 4 3 01 02 0 00 1 00000040 0 0 000
1 ffffffff 5ffffc64 0 0 0 0 0 0 1 0d 4 3 03 04 0 00 1 fffffffc 0 0 000
1 00002018 4e0000a1 0 0 0 0 0 0 1 0e 4 1 05 00 1 01 1 fffe0000 0 0 000
1 0000201c 142468a7 0 0 0 0 0 0 1 0f 1 0 00 00 1 07 1 12345000 0 0 000
1 00002020 1dffffe9 0 0 0 0 0 0 1 10 1 0 00 00 1 09 1 fffff000 0 0 000
1 00002024 50040000 0 0 0 0 0 0 1 11 4 0 00 00 0 00 1 00000400 0 0 000
1 00002028 57fffbff 1 0 0 0 0 0 1 12 4 0 00 00 1 01 1 fffffff8 0 0 000
1 00003000 04001804 0 0 0 0 0 0 1 13 5 0 00 00 1 04 1 00000006 0 0 000
1 00003004 04000425 0 0 0 0 0 0 1 14 5 2 00 05 1 05 1 00000001 0 0 000
1 00003008 040ffce6 0 0 0 0 3 0 1 15 5 3 07 06 1 06 1 000003ff 0 1 100
1 0000300c 04001804 0 0 0 0 3 0 1 13 5 0 00 00 1 04 1 00000006 0 1 100
1 00003010 06483800 0 0 0 0 0 0 1 16 5 0 00 00 0 00 0 00000000 1 0 000
1 00003014 06483800 0 0 0 0 3 0 1 16 5 0 00 00 0 00 0 00000000 1 1 100
1 00003018 06488000 0 0 0 0 0 0 1 17 5 0 00 00 0 00 0 00000000 0 0 000
1 00004000 ffffffff 0 0 0 0 0 0 1 00 0 0 00 00 0 00 0 00000000 0 1 080
1 00004004 00000000 0 0 0 0 0 0 1 00 0 0 00 00 0 00 0 00000000 0 1 080
0 00004008 00100823 1 1 5 1 3 0 0 00 0 0 00 00 0 00 0 00000000 0 0 000
1 0000400c 00100823 0 1 8 0 0 0 1 01 1 3 01 02 1 03 0 00000000 0 1 010
1 00004010 00100823 0 0 0 1 0 0 1 01 1 3 01 02 1 03 0 00000000 0 1 001
1 00004014 ffffffff 0 1 3 1 0 0 1 00 0 0 00 00 0 00 0 00000000 0 1 087
1 00004018 00100823 0 0 0 0 0 1 0 00 0 0 00 00 0 00 0 00000000 0 0 000
1 0000401c 001118a4 0 0 0 0 0 0 1 02 1 3 05 06 1 04 0 00000000 0 0 000

//--- loong_id.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
decode/decoder_3r.sv
decode/decoder_imm.sv
decode/decoder_csr.sv
decode/id.sv
hdl/id_dispatch_reg.sv
hdl/id_stage_top.sv
tb/tb_id_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ID stage testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f loong_id.f --top-module tb_id_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_id_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Done: no errors" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
